//--- src/uart_pkg.sv
package uart_pkg;

  // channel bus word widths
  typedef logic [7:0] addr_t;
  typedef logic [31:0] data_t;

  // one serial character
  typedef logic [7:0] byte_t;

  // channel number of the serial data register
  localparam addr_t UART_DATA_ADDR = 8'h10;

  // clk cycles per serial bit, small for short runs
  localparam integer CLKS_PER_BIT = 16;

  // divider counter inside one bit time
  typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt_t;
  localparam bit_cnt_t BIT_CNT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
  localparam bit_cnt_t HALF_CNT_LAST = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

  // data bit index within a frame, lsb first
  typedef logic [2:0] bit_idx_t;
  localparam bit_idx_t LAST_DATA_BIT = 3'd7;

  // channel port fsm
  typedef enum logic [1:0] {
    ST_WAIT_CMD,
    ST_SEND_BYTE,
    ST_RECV_BYTE,
    ST_NODATA
  } port_state_t;

  // receiver fsm
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  // transmitter fsm
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

//--- src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic            clk,
  input  logic            rst,
  input  logic            tx_start,
  input  uart_pkg::byte_t tx_byte,
  output logic            txd,
  output logic            tx_busy
);

  uart_pkg::tx_state_t state;
  uart_pkg::bit_cnt_t  cnt;
  uart_pkg::bit_idx_t  bit_idx;
  uart_pkg::byte_t     shift_q;
  logic                bit_end;

  // last clk of the current bit time
  assign bit_end = (cnt == uart_pkg::BIT_CNT_LAST);

  // busy from the cycle after tx_start to the end of the stop bit
  assign tx_busy = (state != uart_pkg::TX_IDLE);

  // frame sequencer, txd registered so the line never glitches
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= uart_pkg::TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          // start bit goes out on the next edge
          if (tx_start) begin
            txd   <= 1'b0;
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            cnt   <= '0;
            // first data bit, lsb
            txd   <= shift_q[0];
            state <= uart_pkg::TX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == uart_pkg::LAST_DATA_BIT) begin
              // stop bit
              txd   <= 1'b1;
              state <= uart_pkg::TX_STOP;
            end else begin
              // next bit before the shift below lands
              txd     <= shift_q[1];
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= uart_pkg::TX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // outgoing byte, latched on start and shifted right per bit
  always_ff @(posedge clk) begin
    if (state == uart_pkg::TX_IDLE && tx_start) begin
      shift_q <= tx_byte;
    end else if (state == uart_pkg::TX_DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic            clk,
  input  logic            rst,
  input  logic            rxd,
  output logic            rx_valid,
  output uart_pkg::byte_t rx_byte
);

  logic                rxd_meta;
  logic                rxd_sync;
  logic                rxd_prev;
  logic                start_edge;
  logic                bit_end;
  logic                half_end;
  logic                stop_seen;
  logic                stop_ok;
  uart_pkg::rx_state_t state;
  uart_pkg::bit_cnt_t  cnt;
  uart_pkg::bit_idx_t  bit_idx;
  uart_pkg::byte_t     shift_q;

  // two flop synchronizer plus one stage for edge detect
  // line idles high, so reset to 1
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // falling edge opens a frame
  assign start_edge = rxd_prev & ~rxd_sync;
  assign bit_end    = (cnt == uart_pkg::BIT_CNT_LAST);
  assign half_end   = (cnt == uart_pkg::HALF_CNT_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= uart_pkg::RX_IDLE;
      cnt       <= '0;
      bit_idx   <= '0;
      stop_seen <= 1'b0;
      stop_ok   <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      // strobe, one cycle only
      rx_valid <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          cnt <= '0;
          if (start_edge) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          // recheck at mid start bit, high again means a glitch
          if (half_end) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::RX_DATA: begin
          // counter now aligned to mid-bit
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == uart_pkg::LAST_DATA_BIT) begin
              stop_seen <= 1'b0;
              state     <= uart_pkg::RX_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::RX_STOP: begin
          if (!stop_seen && bit_end) begin
            // mid stop bit, low means framing error
            cnt       <= '0;
            stop_seen <= 1'b1;
            stop_ok   <= rxd_sync;
          end else if (stop_seen && half_end) begin
            // end of stop bit, report only good frames
            cnt      <= '0;
            rx_valid <= stop_ok;
            state    <= uart_pkg::RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data bits enter at the top, lsb first on the line
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && bit_end) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
  end

  // held stable through the stop bit
  assign rx_byte = shift_q;

endmodule

//--- src/chan_uart_port.sv
`timescale 1ns/1ps

module chan_uart_port (
  input  logic            clk,
  input  logic            rst,
  input  uart_pkg::addr_t chan_no,
  input  uart_pkg::data_t chan_data,
  input  logic            chan_r_q,
  input  logic            chan_w_q,
  output logic            chan_r_dn,
  output logic            chan_w_dn,
  output logic            chan_nodata,
  output uart_pkg::data_t chan_data_out,
  input  logic            rx_valid,
  input  uart_pkg::byte_t rx_byte,
  input  logic            tx_busy,
  output logic            tx_start,
  output uart_pkg::byte_t tx_byte
);

  uart_pkg::port_state_t state;
  uart_pkg::byte_t       rx_buf;
  logic                  rx_full;
  logic                  req_hit;
  logic                  wr_accept;
  logic                  rd_accept;

  // request for this port, only seen while waiting
  assign req_hit = (state == uart_pkg::ST_WAIT_CMD) &&
                   (chan_no == uart_pkg::UART_DATA_ADDR) &&
                   (chan_r_q || chan_w_q);

  // write goes through only with an idle transmitter
  assign wr_accept = req_hit && chan_w_q && !tx_busy;

  // read goes through only with a full buffer
  assign rd_accept = req_hit && chan_r_q && rx_full;

  // response fsm
  // every response lasts exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= uart_pkg::ST_WAIT_CMD;
      chan_r_dn     <= 1'b0;
      chan_w_dn     <= 1'b0;
      chan_nodata   <= 1'b0;
      chan_data_out <= '0;
      tx_start      <= 1'b0;
      rx_full       <= 1'b0;
    end else begin
      case (state)
        uart_pkg::ST_WAIT_CMD: begin
          if (wr_accept) begin
            // byte handed to the transmitter
            tx_start  <= 1'b1;
            chan_w_dn <= 1'b1;
            state     <= uart_pkg::ST_SEND_BYTE;
          end else if (rd_accept) begin
            // zero-extended buffer, buffer emptied
            chan_data_out <= uart_pkg::data_t'(rx_buf);
            chan_r_dn     <= 1'b1;
            rx_full       <= 1'b0;
            state         <= uart_pkg::ST_RECV_BYTE;
          end else if (req_hit) begin
            // busy tx or empty buffer
            chan_nodata <= 1'b1;
            state       <= uart_pkg::ST_NODATA;
          end
        end
        uart_pkg::ST_SEND_BYTE: begin
          tx_start  <= 1'b0;
          chan_w_dn <= 1'b0;
          state     <= uart_pkg::ST_WAIT_CMD;
        end
        uart_pkg::ST_RECV_BYTE: begin
          chan_r_dn     <= 1'b0;
          chan_data_out <= '0;
          state         <= uart_pkg::ST_WAIT_CMD;
        end
        uart_pkg::ST_NODATA: begin
          chan_nodata <= 1'b0;
          state       <= uart_pkg::ST_WAIT_CMD;
        end
        default: begin
          state <= uart_pkg::ST_WAIT_CMD;
        end
      endcase

      // new byte lands after a same-cycle read
      // so it survives in the buffer
      if (rx_valid) begin
        rx_full <= 1'b1;
      end
    end
  end

  // receive buffer byte
  // an unread byte is simply overwritten
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_buf <= rx_byte;
    end
  end

  // outgoing byte, low part of the write data
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      tx_byte <= chan_data[7:0];
    end
  end

endmodule

//--- src/uart_subsys.sv
`timescale 1ns/1ps

module uart_subsys (
  input  logic            clk,
  input  logic            rst,
  input  uart_pkg::addr_t chan_no,
  input  uart_pkg::data_t chan_data,
  input  logic            chan_r_q,
  input  logic            chan_w_q,
  output logic            chan_r_dn,
  output logic            chan_w_dn,
  output logic            chan_nodata,
  output uart_pkg::data_t chan_data_out,
  input  logic            rxd,
  output logic            txd
);

  // receiver to port
  logic            rx_valid;
  uart_pkg::byte_t rx_byte;

  // port to transmitter and back
  logic            tx_start;
  uart_pkg::byte_t tx_byte;
  logic            tx_busy;

  // channel side, owns the receive buffer
  chan_uart_port port_i (
    .clk           (clk),
    .rst           (rst),
    .chan_no       (chan_no),
    .chan_data     (chan_data),
    .chan_r_q      (chan_r_q),
    .chan_w_q      (chan_w_q),
    .chan_r_dn     (chan_r_dn),
    .chan_w_dn     (chan_w_dn),
    .chan_nodata   (chan_nodata),
    .chan_data_out (chan_data_out),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .tx_busy       (tx_busy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte)
  );

  // serial in
  uart_rx rx_i (
    .clk      (clk),
    .rst      (rst),
    .rxd      (rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  // serial out
  uart_tx tx_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

endmodule

//--- tb/tb_uart_serial.svh
`ifndef TB_UART_SERIAL_SVH
`define TB_UART_SERIAL_SVH

// one bit time on rxd, returns 2 ns after an edge
task automatic hold_rxd_bit(input logic level);
  rxd = level;
  repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
  #2;
endtask

// idle gap in whole bit times
task automatic wait_bits(input int n);
  repeat (n * uart_pkg::CLKS_PER_BIT) @(posedge clk);
  #2;
endtask

// 8N1 frame on rxd, lsb first
// bad_stop drives a low stop bit
task automatic send_frame(input uart_pkg::byte_t b, input logic bad_stop);
  hold_rxd_bit(1'b0);
  for (int i = 0; i < 8; i++) begin
    hold_rxd_bit(b[i]);
  end
  hold_rxd_bit(!bad_stop);
  rxd = 1'b1;
endtask

// txd monitor, samples mid-bit and queues each byte
task automatic watch_txd();
  uart_pkg::byte_t b;
  forever begin
    @(negedge txd);
    repeat (uart_pkg::CLKS_PER_BIT / 2) @(posedge clk);
    #5;
    check_equal(txd, 1'b0, "txd start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
      #5;
      b[i] = txd;
    end
    repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
    #5;
    check_equal(txd, 1'b1, "txd stop bit");
    tx_seen.push_back(b);
  end
endtask

`endif

//--- tb/tb_uart_subsys.sv
`timescale 1ns/1ps

module tb_uart_subsys;

  typedef enum {RESP_NONE, RESP_R_DN, RESP_W_DN, RESP_NODATA} resp_t;

  localparam int N_WRITES = 6;
  localparam int N_READS = 3;
  localparam int N_FILTER = 8;
  // frames over the run, each quiet window counts as one
  localparam int N_FRAMES = N_WRITES + 2 + N_READS + 5 + 2;
  localparam int FRAME_CYCLES = 12 * uart_pkg::CLKS_PER_BIT;

  logic            clk = 1'b0;
  logic            rst;
  uart_pkg::addr_t chan_no;
  uart_pkg::data_t chan_data;
  logic            chan_r_q;
  logic            chan_w_q;
  logic            chan_r_dn;
  logic            chan_w_dn;
  logic            chan_nodata;
  uart_pkg::data_t chan_data_out;
  logic            rxd;
  logic            txd;

  integer seed;
  int     cyc = 0;
  int     checks = 0;
  int     errors = 0;
  int     test_checks;
  int     test_errors;

  // reference model, buffer plus tx bookkeeping
  uart_pkg::byte_t model_buf;
  logic            model_full;
  int              last_tx_edge;
  uart_pkg::byte_t exp_tx[$];
  uart_pkg::byte_t tx_seen[$];

  uart_subsys uart_subsys_i (
    .clk           (clk),
    .rst           (rst),
    .chan_no       (chan_no),
    .chan_data     (chan_data),
    .chan_r_q      (chan_r_q),
    .chan_w_q      (chan_w_q),
    .chan_r_dn     (chan_r_dn),
    .chan_w_dn     (chan_w_dn),
    .chan_nodata   (chan_nodata),
    .chan_data_out (chan_data_out),
    .rxd           (rxd),
    .txd           (txd)
  );

  always #20 clk = ~clk;

  // edge index, read 2 ns after an edge
  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  `include "tb_uart_serial.svh"

  task automatic check_idle_outputs(input string when_txt);
    check_equal(chan_r_dn, 1'b0, {"chan_r_dn ", when_txt});
    check_equal(chan_w_dn, 1'b0, {"chan_w_dn ", when_txt});
    check_equal(chan_nodata, 1'b0, {"chan_nodata ", when_txt});
    check_equal(chan_data_out, '0, {"chan_data_out ", when_txt});
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // one request, entered and left 2 ns after an edge
  // quiet before the edge, response for one cycle, quiet after
  task automatic chan_access(input logic wr, input uart_pkg::addr_t no,
                             input uart_pkg::data_t data, input resp_t exp_resp,
                             input uart_pkg::data_t exp_dout);
    chan_no   = no;
    chan_data = data;
    chan_w_q  = wr;
    chan_r_q  = !wr;
    #8;
    check_idle_outputs("before request edge");
    @(posedge clk);
    #2;
    chan_w_q  = 1'b0;
    chan_r_q  = 1'b0;
    chan_no   = '0;
    chan_data = '0;
    #8;
    check_equal(chan_r_dn, exp_resp == RESP_R_DN, "chan_r_dn in response cycle");
    check_equal(chan_w_dn, exp_resp == RESP_W_DN, "chan_w_dn in response cycle");
    check_equal(chan_nodata, exp_resp == RESP_NODATA, "chan_nodata in response cycle");
    check_equal(chan_data_out, (exp_resp == RESP_R_DN) ? exp_dout : '0,
                "chan_data_out in response cycle");
    @(posedge clk);
    #2;
    check_idle_outputs("after response cycle");
  endtask

  // tx busy from the edge after acceptance to the end of the stop bit
  task automatic write_byte(input uart_pkg::data_t data);
    int    req_edge;
    resp_t exp;
    req_edge = cyc + 1;
    if (req_edge - last_tx_edge <= 1 + 10 * uart_pkg::CLKS_PER_BIT) begin
      exp = RESP_NODATA;
    end else begin
      exp = RESP_W_DN;
      last_tx_edge = req_edge;
      exp_tx.push_back(data[7:0]);
    end
    chan_access(1'b1, uart_pkg::UART_DATA_ADDR, data, exp, '0);
  endtask

  task automatic read_byte();
    if (model_full) begin
      model_full = 1'b0;
      chan_access(1'b0, uart_pkg::UART_DATA_ADDR, '0, RESP_R_DN, {24'd0, model_buf});
    end else begin
      chan_access(1'b0, uart_pkg::UART_DATA_ADDR, '0, RESP_NODATA, '0);
    end
  endtask

  // frame plus one bit time for the receiver to report
  task automatic receive_frame(input uart_pkg::byte_t b, input logic bad_stop);
    send_frame(b, bad_stop);
    wait_bits(1);
    if (!bad_stop) begin
      model_buf  = b;
      model_full = 1'b1;
    end
  endtask

  task automatic check_tx_frame();
    int waited;
    waited = 0;
    while (tx_seen.size() == 0 && waited < FRAME_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (tx_seen.size() == 0) begin
      errors++;
      $display("no frame appeared on txd within %0d cycles of a write", FRAME_CYCLES);
    end else if (exp_tx.size() == 0) begin
      errors++;
      $display("a frame appeared on txd without an accepted write");
      void'(tx_seen.pop_front());
    end else begin
      check_equal(tx_seen.pop_front(), exp_tx.pop_front(), "byte captured on txd");
    end
  endtask

  task automatic check_no_tx();
    wait_bits(12);
    check_equal(tx_seen.size(), 0, "frames on txd");
  endtask

  initial begin
    uart_pkg::addr_t no;
    logic            wr;
    seed         = 80;
    rst          = 1'b1;
    chan_no      = '0;
    chan_data    = '0;
    chan_r_q     = 1'b0;
    chan_w_q     = 1'b0;
    rxd          = 1'b1;
    model_buf    = '0;
    model_full   = 1'b0;
    last_tx_edge = -100000;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    fork
      watch_txd();
    join_none

    start_test();
    repeat (20) begin
      #8;
      check_equal(txd, 1'b1, "txd idle after reset");
      check_idle_outputs("idle after reset");
      @(posedge clk);
      #2;
    end
    finish_test("1 idle after reset");

    start_test();
    for (int i = 0; i < N_WRITES; i++) begin
      write_byte($random(seed));
      check_tx_frame();
      wait_bits(1);
    end
    finish_test("2 writes");

    // second write lands two cycles after the first
    start_test();
    write_byte($random(seed));
    write_byte($random(seed));
    check_tx_frame();
    check_no_tx();
    finish_test("3 write while busy");

    start_test();
    for (int i = 0; i < N_READS; i++) begin
      read_byte();
      receive_frame($random(seed), 1'b0);
      read_byte();
      read_byte();
    end
    finish_test("4 reads");

    // overwrite, then bad stop bit with full and empty buffer
    start_test();
    receive_frame($random(seed), 1'b0);
    receive_frame($random(seed), 1'b0);
    read_byte();
    receive_frame($random(seed), 1'b0);
    receive_frame($random(seed), 1'b1);
    read_byte();
    receive_frame($random(seed), 1'b1);
    read_byte();
    finish_test("5 overwrite and framing error");

    // buffer full, so a filtered read must not drain it
    start_test();
    receive_frame($random(seed), 1'b0);
    for (int i = 0; i < N_FILTER; i++) begin
      do begin
        no = $random(seed);
      end while (no == uart_pkg::UART_DATA_ADDR);
      wr = $random(seed);
      chan_access(wr, no, $random(seed), RESP_NONE, '0);
      @(posedge clk);
      #2;
      check_idle_outputs("third cycle after filtered request");
    end
    check_no_tx();
    read_byte();
    finish_test("6 address filter");

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // about 12 bit times per frame plus slack for reset and requests
  initial begin
    repeat (N_FRAMES * FRAME_CYCLES + 1000) @(posedge clk);
    $display("timeout: the run did not finish in the cycles allowed for %0d frames",
             N_FRAMES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+tb
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/chan_uart_port.sv
src/uart_subsys.sv
tb/tb_uart_subsys.sv

//--- Bender.yml
package:
  name: uart_subsys

sources:
  - src/uart_pkg.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/chan_uart_port.sv
  - src/uart_subsys.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_uart_subsys.sv
